// ==== common/board_macros.svh ====
/*
  Width, boot length, flash timing and strap constants
*/
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// ----------------------------------------
// Bus widths
`define SRAM_ADDR_W   18        // SRAM word address bits
`define SRAM_DATA_W   16        // SRAM word bits
`define SRAM_LANES    2         // Byte lanes per SRAM word
`define FLASH_ADDR_W  22        // Flash byte address bits
`define FLASH_DATA_W  8         // Flash data bits

// ----------------------------------------
// Boot copy
`define BOOT_WORDS    64        // Words copied to the bottom of SRAM
`define FLASH_WAIT    4         // Cycles from fl_addr change to fl_dq sample
`define BOOT_STRAP_COPY 4'b0010 // Strap code that enables the copy

`endif

// ==== common/board_pkg.sv ====
/*
  Data types for the SRAM, the flash and the host bus
*/
`default_nettype none

`include "board_macros.svh"

package board_pkg;

  // ----------------------------------------
  // SRAM and host bus
  typedef logic [`SRAM_ADDR_W-1:0]  sram_addr_t;  // Word address, also host address
  typedef logic [`SRAM_DATA_W-1:0]  sram_data_t;  // One SRAM or host word
  typedef logic [`SRAM_LANES-1:0]   byte_lane_t;  // Active high, bit 0 low byte

  // ----------------------------------------
  // Parallel flash
  typedef logic [`FLASH_ADDR_W-1:0] flash_addr_t; // Byte address
  typedef logic [`FLASH_DATA_W-1:0] flash_byte_t; // One flash byte

endpackage

`default_nettype wire

// ==== common/ctrl_pkg.sv ====
/*
  State encodings for the host slave, boot copier and arbiter FSMs
*/
`default_nettype none

package ctrl_pkg;

  typedef enum logic [1:0] {
    H_IDLE,     // Waiting for chip select
    H_REQ,      // First request cycle
    H_WAIT_ACK, // Request held until ack
    H_HOLD      // Access done, waiting for deselect
  } host_state_e;

  typedef enum logic [2:0] {
    B_IDLE,     // Strap sample after reset
    B_FL_ADDR,  // Drive next flash byte address
    B_FL_WAIT,  // Flash access time
    B_WR_REQ,   // First write request cycle
    B_WAIT_ACK, // Write held until ack
    B_DONE      // Copy finished or skipped
  } boot_state_e;

  typedef enum logic [1:0] {
    A_IDLE,     // Grant point
    A_ACCESS,   // SRAM strobes active
    A_FINISH    // Ack cycle
  } arb_state_e;

endpackage

`default_nettype wire

// ==== common/sram_if.sv ====
/*
  SRAM request channel from one client to the arbiter
  Modports client and arbiter
*/
`default_nettype none

interface sram_if;
  import board_pkg::*;

  logic       req;   // Level, held with all fields until ack
  logic       we;    // Write when high
  sram_addr_t addr;  // Word address
  sram_data_t wdata; // Write data
  byte_lane_t be;    // Write lanes, active high
  logic       ack;   // One-cycle done pulse
  sram_data_t rdata; // Valid in the ack cycle

  modport client (
    output req, we, addr, wdata, be,
    input  ack, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata, be,
    output ack, rdata
  );

endinterface

`default_nettype wire

// ==== sram/sram_arbiter.sv ====
/*
  Fixed-priority SRAM arbiter, host over boot
  Three-cycle sequencer for the asynchronous SRAM pins
*/
`default_nettype none

module sram_arbiter (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  sram_if.arbiter                     host_port,
  sram_if.arbiter                     boot_port,
  output board_pkg::sram_addr_t       sram_addr,
  output board_pkg::sram_data_t       sram_dq_out,
  input  wire board_pkg::sram_data_t  sram_dq_in,
  output logic                        sram_dq_oe,
  output logic                        sram_ce_n,
  output logic                        sram_oe_n,
  output logic                        sram_we_n,
  output logic                        sram_ub_n,
  output logic                        sram_lb_n
);
  import board_pkg::*;
  import ctrl_pkg::*;

  arb_state_e state;
  logic       grant_host;          // Winner of the current access
  logic       ack_host, ack_boot;
  sram_data_t rdata_q;

  // ----------------------------------------
  // Winner select, host first
  logic       any_req;
  logic       sel_we;
  byte_lane_t sel_be;

  assign any_req = host_port.req | boot_port.req;
  assign sel_we  = host_port.req ? host_port.we : boot_port.we;
  assign sel_be  = host_port.req ? host_port.be : boot_port.be;

  // ----------------------------------------
  // Control FSM and strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= A_IDLE;
      grant_host <= 1'b0;
      ack_host   <= 1'b0;
      ack_boot   <= 1'b0;
      sram_ce_n  <= 1'b1;
      sram_oe_n  <= 1'b1;
      sram_we_n  <= 1'b1;
      sram_ub_n  <= 1'b1;
      sram_lb_n  <= 1'b1;
      sram_dq_oe <= 1'b0;
    end else begin
      ack_host <= 1'b0;                    // Acks are single pulses
      ack_boot <= 1'b0;
      case (state)
        A_IDLE: if (any_req) begin
          grant_host <= host_port.req;
          sram_ce_n  <= 1'b0;
          sram_oe_n  <= sel_we;            // Read drives OE
          sram_we_n  <= ~sel_we;
          sram_ub_n  <= sel_we & ~sel_be[1]; // Reads take both lanes
          sram_lb_n  <= sel_we & ~sel_be[0];
          sram_dq_oe <= sel_we;
          state      <= A_ACCESS;
        end
        A_ACCESS: begin
          ack_host   <= grant_host;
          ack_boot   <= ~grant_host;
          sram_ce_n  <= 1'b1;              // Release all strobes
          sram_oe_n  <= 1'b1;
          sram_we_n  <= 1'b1;
          sram_ub_n  <= 1'b1;
          sram_lb_n  <= 1'b1;
          sram_dq_oe <= 1'b0;
          state      <= A_FINISH;
        end
        A_FINISH: state <= A_IDLE;         // Client drops req here
        default:  state <= A_IDLE;
      endcase
    end
  end

  // Address, write data and read capture
  always_ff @(posedge clk) begin
    if (state == A_IDLE && any_req) begin
      sram_addr   <= host_port.req ? host_port.addr : boot_port.addr;
      sram_dq_out <= host_port.req ? host_port.wdata : boot_port.wdata;
    end
    if (state == A_ACCESS)
      rdata_q <= sram_dq_in;               // Sample at end of access
  end

  assign host_port.ack   = ack_host;
  assign boot_port.ack   = ack_boot;
  assign host_port.rdata = rdata_q;
  assign boot_port.rdata = rdata_q;

  // ----------------------------------------
  // Checks
  a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
    !(host_port.ack && boot_port.ack)) else $error("Both clients acked");

  a_we_oe: assert property (@(posedge clk) disable iff (!rst_n)
    !(!sram_we_n && !sram_oe_n)) else $error("SRAM WE and OE both low");

endmodule

`default_nettype wire

// ==== hdl/host_bus_slave.sv ====
/*
  Asynchronous host bus slave, strobe synchronizers
  One SRAM request per chip select
*/
`default_nettype none

module host_bus_slave (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   host_cs_n,
  input  wire logic                   host_oe_n,
  input  wire logic                   host_we_n,
  input  wire board_pkg::byte_lane_t  host_bls_n,
  input  wire board_pkg::sram_addr_t  host_addr,
  input  wire board_pkg::sram_data_t  host_din,
  output board_pkg::sram_data_t       host_dout,
  output logic                        host_dout_en,
  sram_if.client                      sram_port
);
  import board_pkg::*;
  import ctrl_pkg::*;

  // ----------------------------------------
  // Strobe synchronizers
  // Bit order {cs_n, oe_n, we_n, bls_n[1:0]}
  logic [4:0] strb_s1, strb_s2;
  logic       cs_q;                       // Previous synchronized cs_n
  logic       cs_s, oe_s, we_s;
  byte_lane_t bls_s;
  logic       cs_fall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strb_s1 <= '1;                      // All strobes idle high
      strb_s2 <= '1;
      cs_q    <= 1'b1;
    end else begin
      strb_s1 <= {host_cs_n, host_oe_n, host_we_n, host_bls_n};
      strb_s2 <= strb_s1;
      cs_q    <= cs_s;
    end
  end

  assign {cs_s, oe_s, we_s, bls_s} = strb_s2;
  assign cs_fall = cs_q & ~cs_s;          // New select seen

  // ----------------------------------------
  // Access FSM
  host_state_e state;
  logic        dout_loaded;               // Read data held for this select

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= H_IDLE;
      sram_port.req <= 1'b0;
      dout_loaded   <= 1'b0;
    end else begin
      case (state)
        H_IDLE: if (cs_fall) begin
          sram_port.req <= 1'b1;          // Fields latched same edge
          state         <= H_REQ;
        end
        H_REQ, H_WAIT_ACK: begin
          if (sram_port.ack) begin
            sram_port.req <= 1'b0;
            dout_loaded   <= ~sram_port.we;
            state         <= H_HOLD;
          end else begin
            state <= H_WAIT_ACK;
          end
        end
        H_HOLD: if (cs_s) begin           // Wait for deselect
          dout_loaded <= 1'b0;            // Stale data never enabled again
          state       <= H_IDLE;
        end
        default: state <= H_IDLE;
      endcase
    end
  end

  // Request fields and read data
  always_ff @(posedge clk) begin
    if (state == H_IDLE && cs_fall) begin
      sram_port.addr  <= host_addr;       // Stable since cs setup
      sram_port.wdata <= host_din;
      sram_port.we    <= ~we_s;
      sram_port.be    <= ~bls_s;          // Pins are active low
    end
    if (sram_port.ack && !sram_port.we)
      host_dout <= sram_port.rdata;
  end

  assign host_dout_en = dout_loaded & ~cs_s & ~oe_s;

  // ----------------------------------------
  // Host keeps cs high long enough for the arbiter to finish
  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    cs_fall |-> !sram_port.req) else $error("Host select during pending request");

endmodule

`default_nettype wire

// ==== hdl/flash_boot_copier.sv ====
/*
  Boot copy engine, flash bytes packed into SRAM words
*/
`default_nettype none

`include "board_macros.svh"

module flash_boot_copier (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic [3:0]             boot_strap,
  output board_pkg::flash_addr_t      fl_addr,
  input  wire board_pkg::flash_byte_t fl_dq,
  output logic                        fl_ce_n,
  output logic                        fl_oe_n,
  output logic                        boot_done,
  sram_if.client                      sram_port
);
  import board_pkg::*;
  import ctrl_pkg::*;

  localparam int WAIT_W = $clog2(`FLASH_WAIT + 1);
  localparam flash_addr_t BOOT_BYTES = flash_addr_t'(2 * `BOOT_WORDS);

  boot_state_e         state;
  flash_addr_t         byte_addr;         // Next flash byte
  logic [WAIT_W-1:0]   wait_cnt;
  logic                byte_ready;        // fl_dq settled this cycle
  flash_byte_t         lo_byte;           // Even byte of the word

  assign byte_ready = (state == B_FL_WAIT) && (wait_cnt == WAIT_W'(`FLASH_WAIT - 1));

  // ----------------------------------------
  // Copy FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= B_IDLE;
      byte_addr     <= '0;
      wait_cnt      <= '0;
      fl_addr       <= '0;
      fl_ce_n       <= 1'b1;
      fl_oe_n       <= 1'b1;
      boot_done     <= 1'b0;
      sram_port.req <= 1'b0;
    end else begin
      case (state)
        B_IDLE: begin
          if (boot_strap == `BOOT_STRAP_COPY) begin
            fl_ce_n <= 1'b0;              // Flash on for the whole copy
            fl_oe_n <= 1'b0;
            state   <= B_FL_ADDR;
          end else begin
            boot_done <= 1'b1;            // No copy, no flash access
            state     <= B_DONE;
          end
        end
        B_FL_ADDR: begin
          fl_addr  <= byte_addr;
          wait_cnt <= '0;
          state    <= B_FL_WAIT;
        end
        B_FL_WAIT: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (byte_ready) begin
            byte_addr <= byte_addr + 1'b1;
            if (byte_addr[0]) begin
              sram_port.req <= 1'b1;      // Odd byte completes the word
              state         <= B_WR_REQ;
            end else begin
              state <= B_FL_ADDR;
            end
          end
        end
        B_WR_REQ, B_WAIT_ACK: begin
          if (sram_port.ack) begin
            sram_port.req <= 1'b0;
            if (byte_addr == BOOT_BYTES) begin
              fl_ce_n   <= 1'b1;
              fl_oe_n   <= 1'b1;
              boot_done <= 1'b1;
              state     <= B_DONE;
            end else begin
              state <= B_FL_ADDR;
            end
          end else begin
            state <= B_WAIT_ACK;
          end
        end
        B_DONE:  state <= B_DONE;         // Held until reset
        default: state <= B_IDLE;
      endcase
    end
  end

  // Byte packing, word n at SRAM address n
  always_ff @(posedge clk) begin
    if (byte_ready && !byte_addr[0])
      lo_byte <= fl_dq;
    if (byte_ready && byte_addr[0]) begin
      sram_port.addr  <= byte_addr[`SRAM_ADDR_W:1];
      sram_port.wdata <= {fl_dq, lo_byte};
    end
  end

  assign sram_port.we = 1'b1;             // Copier only writes
  assign sram_port.be = '1;               // Full word

  a_quiet_done: assert property (@(posedge clk) disable iff (!rst_n)
    boot_done |-> !sram_port.req) else $error("Boot request after done");

endmodule

`default_nettype wire

// ==== hdl/de1_mem_top.sv ====
/*
  Board memory subsystem top, host slave and boot copier
  sharing the SRAM through the arbiter
*/
`default_nettype none

`include "board_macros.svh"

module de1_mem_top (
  input  wire logic                     clock_24,
  input  wire logic                     rst_n,
  input  wire logic [3:0]               boot_strap,
  output logic                          ledg_boot_done,
  // Host bus
  input  wire logic                     host_cs_n,
  input  wire logic                     host_oe_n,
  input  wire logic                     host_we_n,
  input  wire logic [`SRAM_LANES-1:0]   host_bls_n,
  input  wire logic [`SRAM_ADDR_W-1:0]  host_addr,
  input  wire logic [`SRAM_DATA_W-1:0]  host_din,
  output logic [`SRAM_DATA_W-1:0]       host_dout,
  output logic                          host_dout_en,
  // SRAM pins, data bus split
  output board_pkg::sram_addr_t         sram_addr,
  output board_pkg::sram_data_t         sram_dq_out,
  input  wire board_pkg::sram_data_t    sram_dq_in,
  output logic                          sram_dq_oe,
  output logic                          sram_ce_n,
  output logic                          sram_oe_n,
  output logic                          sram_we_n,
  output logic                          sram_ub_n,
  output logic                          sram_lb_n,
  // Flash pins, read only
  output board_pkg::flash_addr_t        fl_addr,
  input  wire board_pkg::flash_byte_t   fl_dq,
  output logic                          fl_ce_n,
  output logic                          fl_oe_n
);

  sram_if host_port ();                   // Host slave to arbiter
  sram_if boot_port ();                   // Boot copier to arbiter

  host_bus_slave i_host_bus_slave (
    .clk(clock_24), .rst_n(rst_n),
    .host_cs_n(host_cs_n), .host_oe_n(host_oe_n), .host_we_n(host_we_n),
    .host_bls_n(host_bls_n), .host_addr(host_addr), .host_din(host_din),
    .host_dout(host_dout), .host_dout_en(host_dout_en),
    .sram_port(host_port.client)
  );

  flash_boot_copier i_flash_boot_copier (
    .clk(clock_24), .rst_n(rst_n), .boot_strap(boot_strap),
    .fl_addr(fl_addr), .fl_dq(fl_dq), .fl_ce_n(fl_ce_n), .fl_oe_n(fl_oe_n),
    .boot_done(ledg_boot_done),           // Green LED
    .sram_port(boot_port.client)
  );

  sram_arbiter i_sram_arbiter (
    .clk(clock_24), .rst_n(rst_n),
    .host_port(host_port.arbiter), .boot_port(boot_port.arbiter),
    .sram_addr(sram_addr), .sram_dq_out(sram_dq_out), .sram_dq_in(sram_dq_in),
    .sram_dq_oe(sram_dq_oe), .sram_ce_n(sram_ce_n), .sram_oe_n(sram_oe_n),
    .sram_we_n(sram_we_n), .sram_ub_n(sram_ub_n), .sram_lb_n(sram_lb_n)
  );

endmodule

`default_nettype wire

// ==== tb/tb_mem_models.sv ====
/*
  Behavioral SRAM with byte lanes and split data bus
  Behavioral parallel flash with a fixed content rule
*/
`default_nettype none

module sram_model (
  input  wire board_pkg::sram_addr_t addr,
  input  wire board_pkg::sram_data_t dq_w,   // Data from the DUT
  input  wire logic                  dq_oe,  // DUT drives the pads
  output board_pkg::sram_data_t      dq_r,   // Data to the DUT
  input  wire logic                  ce_n,
  input  wire logic                  oe_n,
  input  wire logic                  we_n,
  input  wire logic                  ub_n,
  input  wire logic                  lb_n
);
  timeunit 1ns;
  timeprecision 100ps;
  import board_pkg::*;

  sram_data_t mem [0:2**$bits(sram_addr_t)-1]; // Full 2^18 word array
  sram_data_t dq_bus;                          // Pad value seen by the SRAM

  assign dq_bus = dq_oe ? dq_w : 'x;           // Floats unless the DUT drives

  // Address, data and lanes settle with WE on the same clock edge
  always @(negedge we_n) begin
    #1;
    if (!ce_n && !we_n) begin
      if (!lb_n) mem[addr][7:0] = dq_bus[7:0];   // Low lane
      if (!ub_n) mem[addr][15:8] = dq_bus[15:8]; // High lane
    end
  end

  // Both sides driving the pads reads as unknown
  assign dq_r = (!ce_n && !oe_n) ? (dq_oe ? 'x : mem[addr]) : '0;
endmodule

module flash_model (
  input  wire board_pkg::flash_addr_t addr,
  input  wire logic                   ce_n,
  input  wire logic                   oe_n,
  output board_pkg::flash_byte_t      dq
);
  timeunit 1ns;
  timeprecision 100ps;
  import board_pkg::*;

  function automatic flash_byte_t contents(input flash_addr_t a);
    return a[7:0] ^ 8'h5A;                     // Low address byte, scrambled
  endfunction

  assign dq = (!ce_n && !oe_n) ? contents(addr) : '0;
endmodule

`default_nettype wire

// ==== tb/tb_de1_mem.sv ====
/*
  Directed tests for the board memory subsystem
  Host bus tasks, typed compare tasks, boot copy and reset checks
*/
`default_nettype none

`include "board_macros.svh"

module tb_de1_mem;
  timeunit 1ns;
  timeprecision 100ps;
  import board_pkg::*;

  localparam int BOOT_TIMEOUT = 5000;  // Cycles, full copy plus host traffic

  logic        clk = 1'b0;
  logic        rst_n;
  logic [3:0]  boot_strap;
  logic        host_cs_n, host_oe_n, host_we_n;
  byte_lane_t  host_bls_n;             // Active low at the pins
  sram_addr_t  host_addr;
  sram_data_t  host_din, host_dout;
  logic        host_dout_en, ledg_boot_done;
  sram_addr_t  sram_addr;
  sram_data_t  sram_dq_out, sram_dq_in;
  logic        sram_dq_oe, sram_ce_n, sram_oe_n, sram_we_n, sram_ub_n, sram_lb_n;
  flash_addr_t fl_addr;
  flash_byte_t fl_dq;
  logic        fl_ce_n, fl_oe_n;
  logic        watch_flash = 1'b0;     // Flash must stay deselected once set

  de1_mem_top i_de1_mem_top (.clock_24(clk), .*);

  sram_model i_sram_model (
    .addr(sram_addr), .dq_w(sram_dq_out), .dq_oe(sram_dq_oe), .dq_r(sram_dq_in),
    .ce_n(sram_ce_n), .oe_n(sram_oe_n), .we_n(sram_we_n), .ub_n(sram_ub_n),
    .lb_n(sram_lb_n)
  );

  flash_model i_flash_model (.addr(fl_addr), .ce_n(fl_ce_n), .oe_n(fl_oe_n), .dq(fl_dq));

  always #50 clk = ~clk;               // 100 ns period

  // ----------------------------------------
  // Failure handling and compares
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input sram_data_t exp, input sram_data_t act);
    if (act !== exp)
      stop_run($sformatf("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      stop_run($sformatf("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act));
  endtask

  function automatic flash_byte_t flash_byte_at(input flash_addr_t a);
    return a[7:0] ^ 8'h5A;             // Flash content rule
  endfunction

  always @(negedge clk)
    if (watch_flash && fl_ce_n !== 1'b1) stop_run("Flash selected with the copy disabled");

  // ----------------------------------------
  // Host bus master, 12 cycles selected, 5 idle
  task automatic host_write(input sram_addr_t addr, input sram_data_t data,
                            input byte_lane_t bls_n);
    @(negedge clk);
    host_addr  = addr;
    host_din   = data;
    host_bls_n = bls_n;
    host_oe_n  = 1'b1;
    host_we_n  = 1'b0;
    host_cs_n  = 1'b0;
    repeat (12) @(negedge clk);
    host_cs_n  = 1'b1;
    host_we_n  = 1'b1;
    repeat (5) @(negedge clk);
  endtask

  task automatic host_read(input sram_addr_t addr, output sram_data_t data);
    @(negedge clk);
    host_addr  = addr;
    host_bls_n = 2'b00;
    host_we_n  = 1'b1;
    host_oe_n  = 1'b0;
    host_cs_n  = 1'b0;
    repeat (10) @(negedge clk);
    check_bit("host_dout_en", 1'b1, host_dout_en);
    data = host_dout;                  // Sampled at cycle 10
    repeat (2) @(negedge clk);
    host_cs_n  = 1'b1;
    host_oe_n  = 1'b1;
    repeat (5) @(negedge clk);
  endtask

  task automatic read_expect(input sram_addr_t addr, input sram_data_t exp);
    sram_data_t rd;
    host_read(addr, rd);
    check_word($sformatf("host_dout @%h", addr), exp, rd);
  endtask

  task automatic wait_boot_done();
    int cycles;
    cycles = 0;
    while (ledg_boot_done !== 1'b1) begin
      if (cycles == BOOT_TIMEOUT) stop_run("Timeout waiting for ledg_boot_done");
      @(negedge clk);
      cycles++;
    end
  endtask

  // ----------------------------------------
  // Reset and the idle pin state
  task automatic check_reset_state();
    check_bit("sram_ce_n", 1'b1, sram_ce_n);
    check_bit("sram_oe_n", 1'b1, sram_oe_n);
    check_bit("sram_we_n", 1'b1, sram_we_n);
    check_bit("sram_ub_n", 1'b1, sram_ub_n);
    check_bit("sram_lb_n", 1'b1, sram_lb_n);
    check_bit("fl_ce_n", 1'b1, fl_ce_n);
    check_bit("fl_oe_n", 1'b1, fl_oe_n);
    check_bit("sram_dq_oe", 1'b0, sram_dq_oe);
    check_bit("host_dout_en", 1'b0, host_dout_en);
    check_bit("ledg_boot_done", 1'b0, ledg_boot_done);
  endtask

  task automatic apply_reset(input logic [3:0] strap);
    @(negedge clk);
    rst_n      = 1'b0;
    boot_strap = strap;
    host_cs_n  = 1'b1;
    host_oe_n  = 1'b1;
    host_we_n  = 1'b1;
    repeat (5) @(negedge clk);
    check_reset_state();               // During reset
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_reset_state();               // Released, before the next edge
  endtask

  // ----------------------------------------
  // Directed tests
  task automatic host_rw_during_boot();
    host_write(18'h0_0200, 16'h6B2D, 2'b00);
    read_expect(18'h0_0200, 16'h6B2D);
    check_bit("ledg_boot_done", 1'b0, ledg_boot_done); // Copy still running
  endtask

  task automatic boot_copy_readback();
    sram_data_t exp;
    wait_boot_done();
    for (int n = 0; n < `BOOT_WORDS; n++) begin
      exp = {flash_byte_at(flash_addr_t'(2 * n + 1)), flash_byte_at(flash_addr_t'(2 * n))};
      read_expect(sram_addr_t'(n), exp);
    end
  endtask

  task automatic random_rw();
    sram_addr_t addr_q [32];
    sram_data_t data_q [32];
    for (int i = 0; i < 32; i++) begin
      addr_q[i] = sram_addr_t'(`BOOT_WORDS + (i << 12) + ($urandom % 4096)); // Unique per i
      data_q[i] = sram_data_t'($urandom);
      host_write(addr_q[i], data_q[i], 2'b00);
    end
    for (int i = 0; i < 32; i++) read_expect(addr_q[i], data_q[i]);
  endtask

  task automatic byte_lane_merge();
    sram_data_t base;
    sram_data_t patch;
    base  = sram_data_t'($urandom);
    patch = ~base;                     // Every bit differs from base
    host_write(18'h3_F000, base, 2'b00);
    host_write(18'h3_F000, patch, 2'b01); // High lane only
    read_expect(18'h3_F000, {patch[15:8], base[7:0]});
    host_write(18'h3_F001, base, 2'b00);
    host_write(18'h3_F001, patch, 2'b10); // Low lane only
    read_expect(18'h3_F001, {base[15:8], patch[7:0]});
  endtask

  task automatic no_copy_reset();
    host_write(18'h0_0005, 16'hC3E1, 2'b00); // Boot area word kept over reset
    apply_reset(4'b0000);
    watch_flash = 1'b1;
    wait_boot_done();
    read_expect(18'h0_0005, 16'hC3E1);
    repeat (20) @(negedge clk);
  endtask

  initial begin
    rst_n      = 1'b0;
    boot_strap = `BOOT_STRAP_COPY;
    host_cs_n  = 1'b1;
    host_oe_n  = 1'b1;
    host_we_n  = 1'b1;
    host_bls_n = 2'b11;
    host_addr  = '0;
    host_din   = '0;
    void'($urandom(32'h3419));
    apply_reset(`BOOT_STRAP_COPY);
    host_rw_during_boot();
    boot_copy_readback();
    random_rw();
    byte_lane_merge();
    no_copy_reset();
    $display("All tests passed!");
    $finish;
  end
endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/board_pkg.sv
common/ctrl_pkg.sv
common/sram_if.sv
sram/sram_arbiter.sv
hdl/host_bus_slave.sv
hdl/flash_boot_copier.sv
hdl/de1_mem_top.sv
tb/tb_mem_models.sv
tb/tb_de1_mem.sv

// ==== Makefile ====
# Verilator lint and simulation for the board memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_de1_mem
RTL_TOP   ?= de1_mem_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
